/* compile.f */
+incdir+dv
logic/segre_pkg.sv
logic/segre_mem_if.sv
logic/segre_register_file.sv
logic/segre_if_stage.sv
logic/segre_id_stage.sv
logic/segre_ex_stage.sv
logic/segre_mmu.sv
logic/segre_core.sv
dv/segre_core_tb.sv

/* Bender.yml */
package:
  name: segre_core

sources:
  - logic/segre_pkg.sv
  - logic/segre_mem_if.sv
  - logic/segre_register_file.sv
  - logic/segre_if_stage.sv
  - logic/segre_id_stage.sv
  - logic/segre_ex_stage.sv
  - logic/segre_mmu.sv
  - logic/segre_core.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/segre_core_tb.sv

/* dv/segre_tb_program.svh */
`ifndef SEGRE_TB_PROGRAM_SVH
`define SEGRE_TB_PROGRAM_SVH

localparam logic [31:0] VAL_A       = 32'd7;
// Minus 3 as ADDI sign extends it
localparam logic [31:0] VAL_B       = 32'hFFFF_FFFD;
localparam logic [31:0] DATA0       = 32'h1234_5678;
localparam logic [31:0] DATA_ADDR   = 32'h0000_0100;
localparam logic [31:0] MARKER_ADDR = 32'h0000_0300;
localparam logic [31:0] FINISH_ADDR = 32'h0000_03F0;
localparam int          NUM_STORES  = 6;

task automatic load_image();
    for (int i = 0; i < MEM_WORDS; i++) begin
        // Low bits 00 form no valid opcode so stray fetches retire as no-ops
        mem[i]     = {~i[29:0], 2'b00};
        exp_vld[i] = 1'b0;
        exp_val[i] = '0;
    end
    mem[0]  = enc_addi(5'd1, 5'd0, VAL_A[11:0]);
    mem[1]  = enc_addi(5'd2, 5'd1, VAL_B[11:0]);
    mem[2]  = enc_r(7'h00, 5'd3, 5'd1, 5'd2);
    mem[3]  = enc_r(7'h20, 5'd4, 5'd2, 5'd3);
    mem[4]  = enc_sw(5'd3, 5'd0, 12'h200);
    mem[5]  = enc_sw(5'd4, 5'd0, 12'h204);
    mem[6]  = enc_sw(5'd2, 5'd0, 12'h208);
    // Load followed directly by its use
    mem[7]  = enc_lw(5'd5, 5'd0, DATA_ADDR[11:0]);
    mem[8]  = enc_r(7'h00, 5'd6, 5'd5, 5'd1);
    mem[9]  = enc_sw(5'd6, 5'd0, 12'h20C);
    mem[10] = enc_addi(5'd7, 5'd0, VAL_A[11:0]);
    // Taken BEQ jumps over the marker store
    mem[11] = enc_beq(5'd1, 5'd7, 13'd8);
    mem[12] = enc_sw(5'd1, 5'd0, MARKER_ADDR[11:0]);
    mem[13] = enc_beq(5'd1, 5'd2, 13'd8);
    mem[14] = enc_sw(5'd7, 5'd0, 12'h210);
    mem[15] = enc_sw(5'd3, 5'd0, FINISH_ADDR[11:0]);
    mem[16] = enc_beq(5'd0, 5'd0, 13'd0);
    mem[DATA_ADDR[9:2]] = DATA0;
    expect_store(32'h200, VAL_A + (VAL_A + VAL_B));
    expect_store(32'h204, (VAL_A + VAL_B) - (VAL_A + (VAL_A + VAL_B)));
    expect_store(32'h208, VAL_A + VAL_B);
    expect_store(32'h20C, DATA0 + VAL_A);
    expect_store(32'h210, VAL_A);
    expect_store(FINISH_ADDR, VAL_A + (VAL_A + VAL_B));
endtask

`endif

/* dv/segre_core_tb.sv */
`timescale 1ns/1ps

module segre_core_tb;

localparam logic [31:0] BOOT_PC        = 32'h0000_0000;
localparam int          MEM_WORDS      = 256;
localparam int          TIMEOUT_CYCLES = 5000;

logic        clk;
logic        rst = 1'b1;
logic        mm_rdy = 1'b0;
logic [31:0] mm_rdata = '0;
logic [31:0] mm_wdata;
logic [31:0] mm_addr;
logic        mm_rd;
logic        mm_wr;

// Main memory model state
logic [31:0] mem [MEM_WORDS];
logic [31:0] exp_val [MEM_WORDS];
logic        exp_vld [MEM_WORDS];
logic [31:0] lfsr_state = 32'h4b55e9c5;
logic        busy_q = 1'b0;
int          wait_q = 0;
logic        rst_seen_q = 1'b0;
logic        rd_seen_q = 1'b0;
logic [31:0] prev_addr_q = '0;
logic [31:0] prev_wdata_q = '0;
logic        finish_seen = 1'b0;
int          stores_done = 0;
int          value_errs = 0;
int          other_errs = 0;

// RV32I encodings
function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_beq(input logic [4:0] rs1, input logic [4:0] rs2,
                                        input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
endfunction

task automatic expect_store(input logic [31:0] addr, input logic [31:0] value);
    exp_vld[addr[9:2]] = 1'b1;
    exp_val[addr[9:2]] = value;
endtask

// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// Two bits give a latency of 1 to 4 cycles
function automatic int draw_delay();
    int d;
    d = 1;
    for (int b = 0; b < 2; b++) begin
        d = d + (int'(lfsr_state[0]) << b);
        lfsr_state = lfsr_next(lfsr_state);
    end
    return d;
endfunction

`include "segre_tb_program.svh"

segre_core #(
    .BOOT_PC (BOOT_PC)
) UUT (
    .clk_i         (clk),
    .rst_i         (rst),
    .mm_data_rdy_i (mm_rdy),
    .mm_rd_data_i  (mm_rdata),
    .mm_wr_data_o  (mm_wdata),
    .mm_addr_o     (mm_addr),
    .mm_rd_o       (mm_rd),
    .mm_wr_o       (mm_wr)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

always @(posedge clk) begin
    rst_seen_q   <= rst;
    prev_addr_q  <= mm_addr;
    prev_wdata_q <= mm_wdata;
    if (mm_rd) begin
        rd_seen_q <= 1'b1;
    end
    if (rst) begin
        mm_rdy <= 1'b0;
        busy_q <= 1'b0;
        wait_q <= 0;
    end else begin
        mm_rdy <= 1'b0;
        if (mm_rdy) begin
            // Strobe ends on this edge
            busy_q <= 1'b0;
            if (mm_wr) begin
                stores_done <= stores_done + 1;
                if (mm_addr == FINISH_ADDR) begin
                    finish_seen <= 1'b1;
                end
            end
        end else if (!busy_q && (mm_rd || mm_wr)) begin
            busy_q <= 1'b1;
            wait_q <= draw_delay() - 1;
        end else if (busy_q) begin
            if (wait_q == 0) begin
                mm_rdy <= 1'b1;
                if (mm_wr) begin
                    mem[mm_addr[9:2]] = mm_wdata;
                end else begin
                    mm_rdata <= mem[mm_addr[9:2]];
                end
            end else begin
                wait_q <= wait_q - 1;
            end
        end
    end
end

a_reset_quiet: assert property (@(posedge clk) rst_seen_q |-> !(mm_rd || mm_wr))
    else begin
        value_errs++;
        $display("ERR reset: expected rd/wr 0/0 actual %b/%b", $sampled(mm_rd), $sampled(mm_wr));
    end

a_boot_pc: assert property (@(posedge clk) disable iff (rst)
    (mm_rd && !rd_seen_q) |-> (mm_addr == BOOT_PC))
    else begin
        value_errs++;
        $display("ERR boot_pc: expected %h actual %h", BOOT_PC, $sampled(mm_addr));
    end

a_store_value: assert property (@(posedge clk) disable iff (rst)
    (mm_wr && mm_rdy && (mm_addr != MARKER_ADDR)) |->
        (exp_vld[mm_addr[9:2]] && (mm_wdata == exp_val[mm_addr[9:2]])))
    else begin
        value_errs++;
        $display("ERR store_%h: expected %h actual %h", $sampled(mm_addr),
                 exp_val[$sampled(mm_addr[9:2])], $sampled(mm_wdata));
    end

a_marker: assert property (@(posedge clk) disable iff (rst)
    !(mm_wr && (mm_addr == MARKER_ADDR)))
    else begin
        other_errs++;
        $display("A store reached the marker address, so the taken branch fell through");
    end

a_hold: assert property (@(posedge clk) disable iff (rst)
    ((mm_rd || mm_wr) && !mm_rdy) |=>
        ((mm_rd || mm_wr) && (mm_addr == prev_addr_q) && (mm_wdata == prev_wdata_q)))
    else begin
        value_errs++;
        $display("ERR hold: expected addr %h data %h actual addr %h data %h",
                 $sampled(prev_addr_q), $sampled(prev_wdata_q),
                 $sampled(mm_addr), $sampled(mm_wdata));
    end

a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(mm_rd && mm_wr))
    else begin
        other_errs++;
        $display("Read and write strobes were high in the same cycle");
    end

initial begin
    int cycles;
    load_image();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    cycles = 0;
    while (!finish_seen && (cycles < TIMEOUT_CYCLES)) begin
        @(posedge clk);
        cycles++;
    end
    if (!finish_seen) begin
        other_errs++;
        $display("Timed out after %0d cycles waiting for the finish store", cycles);
    end
    assert (stores_done == NUM_STORES)
        else begin
            value_errs++;
            $display("ERR store_count: expected %0d actual %0d", NUM_STORES, stores_done);
        end
    $display("Summary: %0d stores, %0d value errors, %0d other errors",
             stores_done, value_errs, other_errs);
    if ((value_errs + other_errs) == 0) begin
        $display("Test completed successfully");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule : segre_core_tb

/* logic/segre_core.sv */
`timescale 1ns/1ps

module segre_core import segre_pkg::*; #(
    parameter addr_t BOOT_PC = '0
) (
    input  logic  clk_i,
    input  logic  rst_i,
    // Main memory
    input  logic  mm_data_rdy_i,
    input  word_t mm_rd_data_i,
    output word_t mm_wr_data_o,
    output addr_t mm_addr_o,
    output logic  mm_rd_o,
    output logic  mm_wr_o
);

word_t     if_instr;
addr_t     if_pc;
logic      fetch_wait;
logic      tkbr;
addr_t     new_pc;
logic      ex_stall;
logic      id_flush;
id_ex_t    id_ex;
reg_addr_t rf_raddr_a;
reg_addr_t rf_raddr_b;
word_t     rf_data_a;
word_t     rf_data_b;
logic      rf_we;
reg_addr_t rf_waddr;
word_t     rf_wdata;

segre_mem_if ic_mem ();
segre_mem_if dc_mem ();

// Bubble into ID/EX on a taken branch or an empty fetch slot
assign id_flush = tkbr | fetch_wait;

segre_if_stage #(
    .BOOT_PC (BOOT_PC)
) if_stage (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .stall_i      (ex_stall),
    .tkbr_i       (tkbr),
    .new_pc_i     (new_pc),
    .fetch_wait_o (fetch_wait),
    .instr_o      (if_instr),
    .pc_o         (if_pc),
    .ic           (ic_mem.client)
);

segre_id_stage id_stage (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .stall_i      (ex_stall),
    .flush_i      (id_flush),
    .instr_i      (if_instr),
    .pc_i         (if_pc),
    .rf_raddr_a_o (rf_raddr_a),
    .rf_raddr_b_o (rf_raddr_b),
    .rf_data_a_i  (rf_data_a),
    .rf_data_b_i  (rf_data_b),
    .byp_we_i     (rf_we),
    .byp_waddr_i  (rf_waddr),
    .byp_data_i   (rf_wdata),
    .id_ex_o      (id_ex)
);

segre_ex_stage ex_stage (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .id_ex_i    (id_ex),
    .dc         (dc_mem.client),
    .ex_stall_o (ex_stall),
    .tkbr_o     (tkbr),
    .new_pc_o   (new_pc),
    .rf_we_o    (rf_we),
    .rf_waddr_o (rf_waddr),
    .rf_wdata_o (rf_wdata)
);

segre_register_file segre_rf (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .data_a_o  (rf_data_a),
    .data_b_o  (rf_data_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
);

segre_mmu mmu (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .ic            (ic_mem.mmu),
    .dc            (dc_mem.mmu),
    .mm_data_rdy_i (mm_data_rdy_i),
    .mm_rd_data_i  (mm_rd_data_i),
    .mm_rd_o       (mm_rd_o),
    .mm_wr_o       (mm_wr_o),
    .mm_addr_o     (mm_addr_o),
    .mm_wr_data_o  (mm_wr_data_o)
);

endmodule : segre_core

/* logic/segre_mmu.sv */
`timescale 1ns/1ps

module segre_mmu import segre_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_i,
    segre_mem_if.mmu ic,
    segre_mem_if.mmu dc,
    input  logic  mm_data_rdy_i,
    input  word_t mm_rd_data_i,
    output logic  mm_rd_o,
    output logic  mm_wr_o,
    output addr_t mm_addr_o,
    output word_t mm_wr_data_o
);

mmu_state_e state_q;
logic       we_q;
addr_t      addr_q;
word_t      wdata_q;
logic       busy;

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        state_q <= MMU_IDLE;
    end else begin
        case (state_q)
            MMU_IDLE: begin
                // Data side wins when both are pending
                if (dc.req) begin
                    state_q <= MMU_DC;
                end else if (ic.req) begin
                    state_q <= MMU_IC;
                end
            end
            default: begin
                if (mm_data_rdy_i) begin
                    state_q <= MMU_IDLE;
                end
            end
        endcase
    end
end

// Granted request is latched in idle
always_ff @(posedge clk_i) begin
    if (state_q == MMU_IDLE) begin
        we_q    <= dc.req ? dc.we : ic.we;
        addr_q  <= dc.req ? dc.addr : ic.addr;
        wdata_q <= dc.req ? dc.wdata : ic.wdata;
    end
end

assign busy = (state_q != MMU_IDLE);

assign mm_rd_o      = busy && !we_q;
assign mm_wr_o      = busy && we_q;
assign mm_addr_o    = addr_q;
assign mm_wr_data_o = wdata_q;

assign ic.rdy   = (state_q == MMU_IC) && mm_data_rdy_i;
assign dc.rdy   = (state_q == MMU_DC) && mm_data_rdy_i;
assign ic.rdata = mm_rd_data_i;
assign dc.rdata = mm_rd_data_i;

a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(mm_rd_o && mm_wr_o))
    else $error("Main memory read and write strobes both high");

endmodule : segre_mmu

/* logic/segre_ex_stage.sv */
`timescale 1ns/1ps

module segre_ex_stage import segre_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  id_ex_t    id_ex_i,
    segre_mem_if.client dc,
    output logic      ex_stall_o,
    output logic      tkbr_o,
    output addr_t     new_pc_o,
    output logic      rf_we_o,
    output reg_addr_t rf_waddr_o,
    output word_t     rf_wdata_o
);

word_t alu_res;
logic  is_mem;

assign alu_res = (id_ex_i.alu_op == ALU_SUB) ? id_ex_i.src_a - id_ex_i.src_b
                                             : id_ex_i.src_a + id_ex_i.src_b;

assign is_mem = id_ex_i.valid && (id_ex_i.memop_rd || id_ex_i.memop_wr);

// Data request is held by the ID/EX register while stalled
assign dc.req   = is_mem;
assign dc.we    = id_ex_i.memop_wr;
assign dc.addr  = alu_res;
assign dc.wdata = id_ex_i.st_data;

assign ex_stall_o = is_mem && !dc.rdy;

// BEQ
assign tkbr_o   = id_ex_i.valid && id_ex_i.is_branch && (id_ex_i.src_a == id_ex_i.src_b);
assign new_pc_o = id_ex_i.br_target;

// Loads write back in the rdy cycle
assign rf_we_o    = id_ex_i.valid && id_ex_i.rf_we && (!id_ex_i.memop_rd || dc.rdy);
assign rf_waddr_o = id_ex_i.rf_waddr;
assign rf_wdata_o = id_ex_i.memop_rd ? dc.rdata : alu_res;

a_dc_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (dc.req && !dc.rdy) |=>
        (dc.req && $stable(dc.we) && $stable(dc.addr) && $stable(dc.wdata)))
    else $error("Data request changed before rdy");

endmodule : segre_ex_stage

/* logic/segre_id_stage.sv */
`timescale 1ns/1ps

module segre_id_stage import segre_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      stall_i,
    input  logic      flush_i,
    input  word_t     instr_i,
    input  addr_t     pc_i,
    output reg_addr_t rf_raddr_a_o,
    output reg_addr_t rf_raddr_b_o,
    input  word_t     rf_data_a_i,
    input  word_t     rf_data_b_i,
    input  logic      byp_we_i,
    input  reg_addr_t byp_waddr_i,
    input  word_t     byp_data_i,
    output id_ex_t    id_ex_o
);

opcode_t   opcode;
funct3_t   funct3;
funct7_t   funct7;
reg_addr_t rs1;
reg_addr_t rs2;
reg_addr_t rd;
word_t     imm_i;
word_t     imm_s;
word_t     imm_b;
word_t     op_a;
word_t     op_b;
id_ex_t    id_ex_d;
id_ex_t    id_ex_q;

assign opcode = instr_i[6:0];
assign rd     = instr_i[11:7];
assign funct3 = instr_i[14:12];
assign rs1    = instr_i[19:15];
assign rs2    = instr_i[24:20];
assign funct7 = instr_i[31:25];

assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                instr_i[11:8], 1'b0};

assign rf_raddr_a_o = rs1;
assign rf_raddr_b_o = rs2;

// Writeback in EX this cycle is not yet in the register file
assign op_a = (byp_we_i && (byp_waddr_i != '0) && (byp_waddr_i == rs1)) ? byp_data_i
                                                                        : rf_data_a_i;
assign op_b = (byp_we_i && (byp_waddr_i != '0) && (byp_waddr_i == rs2)) ? byp_data_i
                                                                        : rf_data_b_i;

always_comb begin
    id_ex_d           = '0;
    id_ex_d.alu_op    = ALU_ADD;
    id_ex_d.src_a     = op_a;
    id_ex_d.src_b     = op_b;
    id_ex_d.st_data   = op_b;
    id_ex_d.rf_waddr  = rd;
    id_ex_d.br_target = pc_i + imm_b;
    case (opcode)
        OPC_OP: begin
            if ((funct3 == F3_ADD) && ((funct7 == F7_ADD) || (funct7 == F7_SUB))) begin
                id_ex_d.valid  = 1'b1;
                id_ex_d.rf_we  = 1'b1;
                id_ex_d.alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
            end
        end
        OPC_OP_IMM: begin
            id_ex_d.valid = (funct3 == F3_ADD);
            id_ex_d.rf_we = (funct3 == F3_ADD);
            id_ex_d.src_b = imm_i;
        end
        OPC_LOAD: begin
            id_ex_d.valid    = (funct3 == F3_WORD);
            id_ex_d.rf_we    = (funct3 == F3_WORD);
            id_ex_d.memop_rd = (funct3 == F3_WORD);
            id_ex_d.src_b    = imm_i;
        end
        OPC_STORE: begin
            id_ex_d.valid    = (funct3 == F3_WORD);
            id_ex_d.memop_wr = (funct3 == F3_WORD);
            id_ex_d.src_b    = imm_s;
        end
        OPC_BRANCH: begin
            id_ex_d.valid     = (funct3 == F3_BEQ);
            id_ex_d.is_branch = (funct3 == F3_BEQ);
        end
        default: begin
            // Unsupported encodings retire as bubbles
        end
    endcase
    if (rd == '0) begin
        id_ex_d.rf_we = 1'b0;
    end
end

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        id_ex_q <= '0;
    end else if (!stall_i) begin
        id_ex_q <= flush_i ? id_ex_t'('0) : id_ex_d;
    end
end

assign id_ex_o = id_ex_q;

endmodule : segre_id_stage

/* logic/segre_if_stage.sv */
`timescale 1ns/1ps

module segre_if_stage import segre_pkg::*; #(
    parameter addr_t BOOT_PC = '0
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  stall_i,
    input  logic  tkbr_i,
    input  addr_t new_pc_i,
    output logic  fetch_wait_o,
    output word_t instr_o,
    output addr_t pc_o,
    segre_mem_if.client ic
);

addr_t pc_q;
addr_t fetch_pc_q;
logic  req_q;
logic  drop_q;
logic  start;
logic  keep;
logic  skid_valid_q;
word_t skid_instr_q;
addr_t skid_pc_q;
logic  valid_q;
word_t instr_q;
addr_t pc_out_q;

// New fetch only when the skid buffer is free
assign start = !req_q && !skid_valid_q && !tkbr_i;
// Word returned for the current path
assign keep  = ic.rdy && !drop_q && !tkbr_i;

assign ic.req   = req_q;
assign ic.we    = 1'b0;
assign ic.addr  = fetch_pc_q;
assign ic.wdata = '0;

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        req_q  <= 1'b0;
        drop_q <= 1'b0;
        pc_q   <= BOOT_PC;
    end else begin
        if (start) begin
            req_q <= 1'b1;
        end else if (ic.rdy) begin
            req_q <= 1'b0;
        end
        // Word of a fetch still in flight at a branch is discarded
        if (tkbr_i && req_q && !ic.rdy) begin
            drop_q <= 1'b1;
        end else if (ic.rdy) begin
            drop_q <= 1'b0;
        end
        if (tkbr_i) begin
            pc_q <= new_pc_i;
        end else if (keep) begin
            pc_q <= pc_q + 32'd4;
        end
    end
end

// IF/ID register and skid buffer control
always_ff @(posedge clk_i) begin
    if (rst_i || tkbr_i) begin
        valid_q      <= 1'b0;
        instr_q      <= NOP_INSTR;
        skid_valid_q <= 1'b0;
    end else if (stall_i) begin
        if (keep) begin
            skid_valid_q <= 1'b1;
        end
    end else if (skid_valid_q) begin
        valid_q      <= 1'b1;
        instr_q      <= skid_instr_q;
        skid_valid_q <= 1'b0;
    end else begin
        valid_q <= keep;
        instr_q <= keep ? ic.rdata : NOP_INSTR;
    end
end

always_ff @(posedge clk_i) begin
    if (start) begin
        fetch_pc_q <= pc_q;
    end
    if (keep && stall_i) begin
        skid_instr_q <= ic.rdata;
        skid_pc_q    <= fetch_pc_q;
    end
    if (!stall_i) begin
        pc_out_q <= skid_valid_q ? skid_pc_q : fetch_pc_q;
    end
end

assign fetch_wait_o = !valid_q;
assign instr_o      = instr_q;
assign pc_o         = pc_out_q;

endmodule : segre_if_stage

/* logic/segre_register_file.sv */
`timescale 1ns/1ps

module segre_register_file import segre_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  reg_addr_t raddr_a_i,
    input  reg_addr_t raddr_b_i,
    output word_t     data_a_o,
    output word_t     data_b_o,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i
);

word_t rf_q [NUM_REGS];

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        for (int i = 0; i < NUM_REGS; i++) begin
            rf_q[i] <= '0;
        end
    end else if (we_i && (waddr_i != '0)) begin
        // x0 is never written
        rf_q[waddr_i] <= wdata_i;
    end
end

assign data_a_o = rf_q[raddr_a_i];
assign data_b_o = rf_q[raddr_b_i];

a_x0_zero: assert property (@(posedge clk_i) disable iff (rst_i)
    ((raddr_a_i == '0) |-> (data_a_o == '0)) and ((raddr_b_i == '0) |-> (data_b_o == '0)))
    else $error("x0 read back a nonzero value");

endmodule : segre_register_file

/* logic/segre_mem_if.sv */
`timescale 1ns/1ps

interface segre_mem_if import segre_pkg::*; ();

    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
    word_t rdata;
    logic  rdy;

    modport client (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  rdy
    );

    modport mmu (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output rdy
    );

endinterface : segre_mem_if

/* logic/segre_pkg.sv */
package segre_pkg;

    // Datapath widths
    localparam int WORD_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_WORD = 3'b010;
    localparam funct3_t F3_BEQ  = 3'b000;

    localparam funct7_t F7_ADD = 7'b0000000;
    localparam funct7_t F7_SUB = 7'b0100000;

    // ADDI x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    typedef enum logic {
        ALU_ADD,
        ALU_SUB
    } alu_op_e;

    typedef enum logic [1:0] {
        MMU_IDLE,
        MMU_IC,
        MMU_DC
    } mmu_state_e;

    // Decode to execute packet where all zero is a bubble
    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        word_t     src_a;
        word_t     src_b;
        word_t     st_data;
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      memop_rd;
        logic      memop_wr;
        logic      is_branch;
        addr_t     br_target;
    } id_ex_t;

endpackage : segre_pkg
